// File: character_defines.svh
`ifndef CHARACTER_DEFINES_SVH
`define CHARACTER_DEFINES_SVH

// scan coordinate widths.
`define XW 10
`define YW 9

`define ADDR_INIT_X 2'd0
`define ADDR_INIT_Y 2'd1
`define ADDR_STEP   2'd2
`define ADDR_CTRL   2'd3

`define TRANSPARENT_KEY 24'hFF00FF // magenta never draws.

`define HEAD_RGB  24'hF2C28C
`define BODY_RGB  24'h2060C0
`define ARM_RGB   24'hE0A070
`define PANTS_RGB 24'h303030

// offsets are relative to the character's top-left corner.
`define PANTS_OFF_X 0
`define PANTS_OFF_Y 152
`define PANTS_W     100
`define PANTS_H     40
`define BODY_OFF_X  0
`define BODY_OFF_Y  100
`define BODY_W      100
`define BODY_H      60
`define LARM_OFF_X  (-15)
`define RARM_OFF_X  90
`define ARM_OFF_Y   95
`define ARM_W       20
`define ARM_H       60
`define HEAD_OFF_X  0
`define HEAD_OFF_Y  0
`define HEAD_W      100
`define HEAD_H      100
`define HEAD_CORNER 30

`endif

// File: characterPkg.sv
`default_nettype none

package characterPkg;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgbPixel;

  // the same 24 bits seen as colour channels or as a flat key.
  typedef union packed {
    rgbPixel     rgb;
    logic [23:0] raw;
  } pixelWord;

  localparam rgbPixel BLACK = '0; // output colour when nothing is drawn.

endpackage

`default_nettype wire

// File: characterRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "character_defines.svh"

module characterRegs (
  input  logic           clk,
  input  logic           rstN,
  input  logic           wrEn,
  input  logic [1:0]     wrAddr,
  input  logic [15:0]    wrData,
  input  logic           frameStart,
  output logic [`XW-1:0] posX,
  output logic [`YW-1:0] posY,
  output logic           drawEn
);

  logic [`XW-1:0] initX;
  logic [`YW-1:0] initY;
  logic [`XW-1:0] travelX; // distance moved since the last init write.
  logic [`YW-1:0] travelY;
  logic [7:0]     stepX;
  logic [7:0]     stepY;
  logic           motionEn;
  logic           doMove;
  logic [`XW-1:0] stepXExt;
  logic [`YW-1:0] stepYExt;

  // steps are two's complement, so sign extend before adding.
  assign stepXExt = {{(`XW-8){stepX[7]}}, stepX};
  assign stepYExt = {{(`YW-8){stepY[7]}}, stepY};

  assign doMove = frameStart && motionEn;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      initX    <= '0;
      initY    <= '0;
      travelX  <= '0;
      travelY  <= '0;
      stepX    <= '0;
      stepY    <= '0;
      drawEn   <= 1'b0;
      motionEn <= 1'b0;
    end else if (wrEn) begin // a write beats a coincident frame pulse.
      case (wrAddr)
        `ADDR_INIT_X: begin
          initX   <= wrData[`XW-1:0];
          travelX <= '0;
        end
        `ADDR_INIT_Y: begin
          initY   <= wrData[`YW-1:0];
          travelY <= '0;
        end
        `ADDR_STEP: begin
          stepX <= wrData[7:0];
          stepY <= wrData[15:8];
        end
        `ADDR_CTRL: begin
          drawEn   <= wrData[0];
          motionEn <= wrData[1];
        end
      endcase
    end else if (doMove) begin
      travelX <= travelX + stepXExt; // wraps at the coordinate width.
      travelY <= travelY + stepYExt;
    end
  end

  // current corner is the init point plus the travel so far.
  assign posX = initX + travelX;
  assign posY = initY + travelY;

endmodule

`default_nettype wire

// File: spritePart.sv
`timescale 1ns/1ps
`default_nettype none

`include "character_defines.svh"

module spritePart #(
  parameter int          OFF_X  = 0,
  parameter int          OFF_Y  = 0,
  parameter int          WIDTH  = 16,
  parameter int          HEIGHT = 16,
  parameter int          CORNER = 0,
  parameter logic [23:0] COLOR  = 24'h000000
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [`XW-1:0]        pixX,
  input  logic [`YW-1:0]        pixY,
  input  logic [`XW-1:0]        posX,
  input  logic [`YW-1:0]        posY,
  input  logic                  drawEn,
  output logic                  hit,
  output characterPkg::rgbPixel color
);

  import characterPkg::*;

  localparam logic [`XW-1:0] OFF_XW = `XW'(OFF_X);
  localparam logic [`YW-1:0] OFF_YW = `YW'(OFF_Y);
  localparam int             CW     = `XW + 2; // room for the sum of two distances.

  pixelWord       partWord;
  logic [`XW-1:0] dx;
  logic [`YW-1:0] dy;
  logic [CW-1:0]  leftD;
  logic [CW-1:0]  rightD;
  logic [CW-1:0]  topD;
  logic [CW-1:0]  bottomD;
  logic           inBox;
  logic           inCut;
  logic           isKey;

  assign partWord.raw = COLOR;
  assign isKey = (partWord.raw == `TRANSPARENT_KEY);

  // position relative to the part's own top-left, wrapping like the raster.
  assign dx = pixX - posX - OFF_XW;
  assign dy = pixY - posY - OFF_YW;

  assign leftD   = CW'(dx);
  assign topD    = CW'(dy);
  assign rightD  = CW'(WIDTH - 1) - leftD; // only meaningful inside the box.
  assign bottomD = CW'(HEIGHT - 1) - topD;

  assign inBox = (leftD < CW'(WIDTH)) && (topD < CW'(HEIGHT));

  // diagonal cut at each of the four corners.
  assign inCut = (leftD + topD < CW'(CORNER)) ||
                 (rightD + topD < CW'(CORNER)) ||
                 (leftD + bottomD < CW'(CORNER)) ||
                 (rightD + bottomD < CW'(CORNER));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      hit <= 1'b0;
    end else begin
      hit <= drawEn && inBox && !inCut && !isKey;
    end
  end

  always_ff @(posedge clk) begin
    color <= partWord.rgb;
  end

endmodule

`default_nettype wire

// File: characterDraw.sv
`timescale 1ns/1ps
`default_nettype none

`include "character_defines.svh"

module characterDraw (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [`XW-1:0]        pixX,
  input  logic [`YW-1:0]        pixY,
  input  logic [`XW-1:0]        posX,
  input  logic [`YW-1:0]        posY,
  input  logic                  drawEn,
  output logic                  pixValid,
  output characterPkg::rgbPixel pixColor
);

  import characterPkg::*;

  localparam int NPARTS = 5;

  logic [NPARTS-1:0] partHit; // index is the layer, higher draws on top.
  rgbPixel           partColor [NPARTS];
  rgbPixel           selColor;

  spritePart #(
    .OFF_X(`PANTS_OFF_X), .OFF_Y(`PANTS_OFF_Y),
    .WIDTH(`PANTS_W), .HEIGHT(`PANTS_H),
    .CORNER(0), .COLOR(`PANTS_RGB)
  ) pantsPart (
    .clk(clk), .rstN(rstN), .drawEn(drawEn),
    .pixX(pixX), .pixY(pixY), .posX(posX), .posY(posY),
    .hit(partHit[0]), .color(partColor[0])
  );

  spritePart #(
    .OFF_X(`BODY_OFF_X), .OFF_Y(`BODY_OFF_Y),
    .WIDTH(`BODY_W), .HEIGHT(`BODY_H),
    .CORNER(0), .COLOR(`BODY_RGB)
  ) bodyPart (
    .clk(clk), .rstN(rstN), .drawEn(drawEn),
    .pixX(pixX), .pixY(pixY), .posX(posX), .posY(posY),
    .hit(partHit[1]), .color(partColor[1])
  );

  spritePart #(
    .OFF_X(`LARM_OFF_X), .OFF_Y(`ARM_OFF_Y),
    .WIDTH(`ARM_W), .HEIGHT(`ARM_H),
    .CORNER(0), .COLOR(`ARM_RGB)
  ) leftArmPart (
    .clk(clk), .rstN(rstN), .drawEn(drawEn),
    .pixX(pixX), .pixY(pixY), .posX(posX), .posY(posY),
    .hit(partHit[2]), .color(partColor[2])
  );

  spritePart #(
    .OFF_X(`RARM_OFF_X), .OFF_Y(`ARM_OFF_Y),
    .WIDTH(`ARM_W), .HEIGHT(`ARM_H),
    .CORNER(0), .COLOR(`ARM_RGB)
  ) rightArmPart (
    .clk(clk), .rstN(rstN), .drawEn(drawEn),
    .pixX(pixX), .pixY(pixY), .posX(posX), .posY(posY),
    .hit(partHit[3]), .color(partColor[3])
  );

  spritePart #(
    .OFF_X(`HEAD_OFF_X), .OFF_Y(`HEAD_OFF_Y),
    .WIDTH(`HEAD_W), .HEIGHT(`HEAD_H),
    .CORNER(`HEAD_CORNER), .COLOR(`HEAD_RGB)
  ) headPart (
    .clk(clk), .rstN(rstN), .drawEn(drawEn),
    .pixX(pixX), .pixY(pixY), .posX(posX), .posY(posY),
    .hit(partHit[4]), .color(partColor[4])
  );

  // later iterations overwrite earlier ones, so the top layer wins.
  always_comb begin
    selColor = BLACK;
    for (int i = 0; i < NPARTS; i++) begin
      if (partHit[i]) begin
        selColor = partColor[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pixValid <= 1'b0;
    end else begin
      pixValid <= |partHit;
    end
  end

  always_ff @(posedge clk) begin
    pixColor <= selColor;
  end

endmodule

`default_nettype wire

// File: characterTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "character_defines.svh"

module characterTop (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  wrEn,
  input  logic [1:0]            wrAddr,
  input  logic [15:0]           wrData,
  input  logic                  frameStart,
  input  logic [`XW-1:0]        pixX,
  input  logic [`YW-1:0]        pixY,
  output logic                  pixValid,
  output characterPkg::rgbPixel pixColor
);

  logic [`XW-1:0] posX; // current top-left corner.
  logic [`YW-1:0] posY;
  logic           drawEn;

  characterRegs characterRegs_i (
    .clk       (clk),
    .rstN      (rstN),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .frameStart(frameStart),
    .posX      (posX),
    .posY      (posY),
    .drawEn    (drawEn)
  );

  // two-stage pixel path, part hit then layer select.
  characterDraw characterDraw_i (
    .clk     (clk),
    .rstN    (rstN),
    .pixX    (pixX),
    .pixY    (pixY),
    .posX    (posX),
    .posY    (posY),
    .drawEn  (drawEn),
    .pixValid(pixValid),
    .pixColor(pixColor)
  );

endmodule

`default_nettype wire

// File: tbCharacterTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "character_defines.svh"

module tbCharacterTop;

  import characterPkg::*;

  localparam int         MAX_RECS   = 128;
  localparam int         CLK_HALF   = 20;
  localparam int         DRIVE_DLY  = 2;
  localparam int         RST_CYCLES = 16;
  localparam logic [3:0] KIND_WRITE = 4'h1;
  localparam logic [3:0] KIND_FRAME = 4'h2;
  localparam logic [3:0] KIND_PROBE = 4'h3;

  logic           clk;
  logic           rstN;
  logic           wrEn;
  logic [1:0]     wrAddr;
  logic [15:0]    wrData;
  logic           frameStart;
  logic [`XW-1:0] pixX;
  logic [`YW-1:0] pixY;
  logic           pixValid;
  rgbPixel        pixColor;

  logic [63:0] recMem [MAX_RECS];
  int          recCount;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  logic        drawOn; // drawEn as the DUT will see it on the next edge.

  // probes in flight, oldest first.
  logic    expCheck [$];
  logic    expValid [$];
  rgbPixel expColor [$];

  characterTop characterTop_i (
    .clk       (clk),
    .rstN      (rstN),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .frameStart(frameStart),
    .pixX      (pixX),
    .pixY      (pixY),
    .pixValid  (pixValid),
    .pixColor  (pixColor)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      stopOnError($sformatf("timeout after %0d cycles", cycleCount));
    end
  end

  task automatic checkValid(input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("CHECK FAILED pixValid got %h expected %h", got, exp));
    end
  endtask

  task automatic checkColor(input rgbPixel got, input rgbPixel exp);
    if (got !== exp) begin
      stopOnError($sformatf(
        "CHECK FAILED pixColor got red %h green %h blue %h expected red %h green %h blue %h",
        got.red, got.green, got.blue, exp.red, exp.green, exp.blue));
    end
  endtask

  task automatic retireProbe();
    logic    chk;
    logic    v;
    rgbPixel c;
    chk = expCheck.pop_front();
    v   = expValid.pop_front();
    c   = expColor.pop_front();
    if (chk) begin
      checkValid(pixValid, v);
      checkColor(pixColor, c);
    end
  endtask

  // a probe driven two edges ago is now at the output.
  task automatic nextCycle();
    @(posedge clk);
    #DRIVE_DLY;
    if (expCheck.size() >= 2) begin
      retireProbe();
    end
  endtask

  task automatic driveProbe(input logic [`XW-1:0] x, input logic [`YW-1:0] y,
                            input logic chk, input logic v, input rgbPixel c);
    pixX = x;
    pixY = y;
    expCheck.push_back(chk);
    expValid.push_back(v);
    expColor.push_back(c);
  endtask

  // random coordinate, only predictable while drawing is off.
  task automatic driveIdle();
    driveProbe(`XW'($urandom), `YW'($urandom), !drawOn, 1'b0, '0);
  endtask

  initial begin
    logic [63:0] rec;
    logic [3:0]  kind;
    rstN       = 1'b0;
    wrEn       = 1'b0;
    wrAddr     = '0;
    wrData     = '0;
    frameStart = 1'b0;
    pixX       = '0;
    pixY       = '0;
    drawOn     = 1'b0;
    void'($urandom(66));

    for (int i = 0; i < MAX_RECS; i++) begin
      recMem[i] = '0;
    end
    $readmemh("character_input.txt", recMem);
    recCount = 0;
    while (recCount < MAX_RECS && recMem[recCount][63:60] != 4'h0) begin
      recCount++;
    end
    if (recCount == 0) begin
      stopOnError("no records found in character_input.txt");
    end
    cycleLimit = 4 * recCount + 200;

    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rstN = 1'b1;

    for (int n = 0; n < recCount; n++) begin
      rec  = recMem[n];
      kind = rec[63:60];
      case (kind)
        KIND_WRITE: begin
          nextCycle();
          wrEn   = 1'b1;
          wrAddr = rec[45:44];
          wrData = rec[43:28];
          driveIdle(); // still judged by the old drawEn.
          if (rec[45:44] == `ADDR_CTRL) begin
            drawOn = rec[28];
          end
          nextCycle();
          wrEn = 1'b0;
          driveIdle();
        end
        KIND_FRAME: begin
          nextCycle();
          frameStart = 1'b1;
          driveIdle();
          nextCycle();
          frameStart = 1'b0;
          driveIdle();
        end
        KIND_PROBE: begin
          nextCycle();
          driveProbe(rec[53:44], rec[36:28], 1'b1, rec[24], rec[23:0]);
        end
        default: begin
          stopOnError($sformatf("record %0d in character_input.txt has an unknown kind", n));
        end
      endcase
    end

    while (expCheck.size() > 0) begin
      @(posedge clk);
      #DRIVE_DLY;
      retireProbe();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
characterPkg.sv
characterRegs.sv
spritePart.sv
characterDraw.sv
characterTop.sv
tbCharacterTop.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --top-module tbCharacterTop -f build.f -o simCharacter \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simCharacter > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: character_input.txt
// kind _ addr or x _ data or y _ valid _ colour, all hex.
// kind 1 is a register write, 2 a frame pulse, 3 a pixel probe with its expected result.
3_0032_0032_0_000000 // after reset, head box at (0,0) not drawn
3_0032_0078_0_000000 // body box
3_0032_00AA_0_000000 // pants box
1_0000_00C8_0_000000 // init x 200
1_0001_0064_0_000000 // init y 100
3_00FA_0096_0_000000 // head centre, drawing still off
1_0003_0001_0_000000 // drawEn on, motion off
3_00FA_0096_1_F2C28C // head centre
3_00FA_00E6_1_2060C0 // body only
3_00FA_0118_1_303030 // pants only
3_00BE_00DC_1_E0A070 // left arm only
3_0131_00DC_1_E0A070 // right arm only
3_015E_0096_0_000000 // right of everything
3_00FA_0127_0_000000 // below the pants
3_00C8_0096_1_F2C28C // head left edge
3_012B_0096_1_F2C28C // head right edge
3_012C_0096_0_000000 // one past the head
3_00CA_00DC_1_E0A070 // left arm over body
3_0127_00FA_1_E0A070 // right arm over body
3_00FA_00FF_1_2060C0 // body over pants
3_00CA_00FD_1_E0A070 // arm over body over pants
3_00D2_006E_0_000000 // top left cut, sum 20
3_00D7_0073_1_F2C28C // top left, sum 30 just outside
3_0122_0069_0_000000 // top right cut, sum 14
3_0118_006F_1_F2C28C // top right, sum 30 just outside
3_011D_00BE_0_000000 // bottom right cut, nothing below
3_00CA_00C5_1_E0A070 // bottom left cut, left arm below
3_0129_00C5_1_E0A070 // bottom right cut, right arm below
1_0002_E214_0_000000 // step x +20, y -30
1_0003_0003_0_000000 // drawEn and motionEn
2_0000_0000_0_000000
2_0000_0000_0_000000
2_0000_0000_0_000000
3_0136_003C_1_F2C28C // corner now at (260,10), head centre
3_0136_008C_1_2060C0 // body
3_00FA_00E6_0_000000 // old body spot is empty
2_0000_0000_0_000000 // corner to (280,492), y wraps
3_014A_001E_1_F2C28C // head centre across the wrap
3_014A_006E_1_2060C0 // body across the wrap
3_014A_01F4_1_F2C28C // head top before the wrap
1_0003_0001_0_000000 // motion off
2_0000_0000_0_000000
2_0000_0000_0_000000
3_014A_001E_1_F2C28C // frozen head
3_014A_006E_1_2060C0 // frozen body
1_0003_0000_0_000000 // drawing off
3_014A_001E_0_000000 // head gone
3_014A_006E_0_000000 // body gone
